// ==== Makefile ====
# Verilator lint and simulation of the graph control unit testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_graph_cu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/graph_cu_consts.svh ====
// Sizes shared by the graph control unit RTL
// Include this before any module or package that needs them

`ifndef GRAPH_CU_CONSTS_SVH
`define GRAPH_CU_CONSTS_SVH

// Unit count and buffer depths
`define GCU_NUM_CU    4
`define GCU_JOB_DEPTH 8
`define GCU_CMD_DEPTH 16

// Field widths
`define GCU_ADDR_W 32
`define GCU_DATA_W 16
`define GCU_SUM_W  32
`define GCU_CNT_W  16
`define GCU_VID_W  16

`endif

// ==== hdl/graph_cu_if.sv ====
// Valid/ready vertex job channel from the dispatcher to one compute unit
`timescale 1ns/1ps
`default_nettype none

`include "graph_cu_consts.svh"

interface cu_job_if;

	logic                   valid;
	logic                   ready;
	logic [`GCU_VID_W-1:0]  vertex_id;
	logic [`GCU_ADDR_W-1:0] edge_start;
	logic [`GCU_CNT_W-1:0]  edge_count;

	// Dispatcher side, fields held with valid until accepted
	modport source (
		output valid, vertex_id, edge_start, edge_count,
		input  ready
	);

	// Compute unit side
	modport sink (
		input  valid, vertex_id, edge_start, edge_count,
		output ready
	);

endinterface

`default_nettype wire

// ==== hdl/graph_cu_pkg.sv ====
// Types used across the graph control unit, plus the round-robin pick
`default_nettype none

`include "graph_cu_consts.svh"

package graph_cu_pkg;

	typedef logic [1:0] cu_id_t;

	typedef struct packed {
		logic [`GCU_VID_W-1:0]  vertex_id;
		logic [`GCU_ADDR_W-1:0] edge_start;
		logic [`GCU_CNT_W-1:0]  edge_count;
	} vertex_job_t;

	typedef struct packed {
		cu_id_t                 cu_id;
		logic [`GCU_ADDR_W-1:0] addr;
	} read_cmd_t;

	typedef struct packed {
		cu_id_t                 cu_id;
		logic [`GCU_DATA_W-1:0] word;
	} read_data_t;

	typedef struct packed {
		logic [`GCU_VID_W-1:0] vertex_id;
		logic [`GCU_SUM_W-1:0] sum;
	} vertex_result_t;

	// First requester at or after ptr, wrapping around
	function automatic cu_id_t rr_pick(input logic [`GCU_NUM_CU-1:0] req, input cu_id_t ptr);
		cu_id_t idx;
		cu_id_t pick;
		logic   hit;
		pick = ptr;
		hit  = 1'b0;
		for (int k = 0; k < `GCU_NUM_CU; k++) begin
			idx = ptr + cu_id_t'(k);
			if (!hit && req[idx]) begin
				pick = idx;
				hit  = 1'b1;
			end
		end
		return pick;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/graph_cu_top.sv ====
// Graph control unit top level: enable and active-unit latches,
// then dispatch, compute units, memory port and result merge
`timescale 1ns/1ps
`default_nettype none

`include "graph_cu_consts.svh"

module graph_cu_top import graph_cu_pkg::*; (
	input  logic                            clock,
	input  logic                            rstn,
	input  logic                            enabled_in,
	input  logic [$clog2(`GCU_NUM_CU):0]    active_cu_count,
	input  logic                            job_valid,
	output logic                            job_ready,
	input  logic [`GCU_VID_W-1:0]           job_vertex,
	input  logic [`GCU_ADDR_W-1:0]          job_edge_start,
	input  logic [`GCU_CNT_W-1:0]           job_edge_count,
	output logic                            rd_cmd_valid,
	input  logic                            rd_cmd_ready,
	output logic [`GCU_ADDR_W-1:0]          rd_cmd_addr,
	output cu_id_t                          rd_cmd_cu,
	input  logic                            rd_data_valid,
	input  cu_id_t                          rd_data_cu,
	input  logic [`GCU_DATA_W-1:0]          rd_data_word,
	output logic                            res_valid,
	input  logic                            res_ready,
	output logic [`GCU_VID_W-1:0]           res_vertex,
	output logic [`GCU_SUM_W-1:0]           res_sum,
	output logic [`GCU_CNT_W-1:0]           vertex_done_count,
	output logic [`GCU_CNT_W-1:0]           edge_done_count
);

	logic                   enabled;
	logic [`GCU_NUM_CU-1:0] cu_enable;
	logic [`GCU_NUM_CU-1:0] mask_next;
	logic [`GCU_NUM_CU-1:0] req_valid;
	logic [`GCU_NUM_CU-1:0] req_ready;
	logic [`GCU_ADDR_W-1:0] req_addr [`GCU_NUM_CU];
	logic [`GCU_NUM_CU-1:0] cu_data_valid;
	logic [`GCU_DATA_W-1:0] cu_data_word;
	logic [`GCU_NUM_CU-1:0] cu_res_valid;
	logic [`GCU_NUM_CU-1:0] cu_res_ready;
	vertex_result_t         cu_res [`GCU_NUM_CU];
	logic [`GCU_CNT_W-1:0]  cu_edge_count [`GCU_NUM_CU];
	vertex_job_t            job_in;
	read_cmd_t              rd_cmd;
	read_data_t             rd_data;
	vertex_result_t         res_out;

	cu_job_if cu_if [`GCU_NUM_CU] ();

	////////////////////////////////////////////////////////////
	// Enable and active-unit latches
	////////////////////////////////////////////////////////////

	// Only the lowest active_cu_count units take jobs
	always_comb begin
		for (int i = 0; i < `GCU_NUM_CU; i++)
			mask_next[i] = (i < active_cu_count);
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled   <= 1'b0;
			cu_enable <= '0;
		end else begin
			enabled <= enabled_in;
			if (enabled_in && active_cu_count != '0)
				cu_enable <= mask_next;
		end
	end

	assign job_in      = '{vertex_id: job_vertex, edge_start: job_edge_start,
		edge_count: job_edge_count};
	assign rd_data     = '{cu_id: rd_data_cu, word: rd_data_word};
	assign rd_cmd_addr = rd_cmd.addr;
	assign rd_cmd_cu   = rd_cmd.cu_id;
	assign res_vertex  = res_out.vertex_id;
	assign res_sum     = res_out.sum;

	////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////

	job_dispatch u_dispatch (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.cu_enable (cu_enable),
		.job_valid (job_valid),
		.job_in    (job_in),
		.job_ready (job_ready),
		.cu_jobs   (cu_if)
	);

	for (genvar i = 0; i < `GCU_NUM_CU; i++) begin : g_cu
		vertex_cu u_cu (
			.clock         (clock),
			.rstn          (rstn),
			.cu_id         (cu_id_t'(i)),
			.job           (cu_if[i]),
			.rd_req_valid  (req_valid[i]),
			.rd_req_ready  (req_ready[i]),
			.rd_req_addr   (req_addr[i]),
			.rd_data_valid (cu_data_valid[i]),
			.rd_data_word  (cu_data_word),
			.res_valid     (cu_res_valid[i]),
			.res_ready     (cu_res_ready[i]),
			.res_out       (cu_res[i])
		);

		// Slot fields stay put until the unit is idle again
		assign cu_edge_count[i] = cu_if[i].edge_count;
	end

	mem_port u_mem_port (
		.clock         (clock),
		.rstn          (rstn),
		.req_valid     (req_valid),
		.req_addr      (req_addr),
		.req_ready     (req_ready),
		.rd_cmd_valid  (rd_cmd_valid),
		.rd_cmd_ready  (rd_cmd_ready),
		.rd_cmd        (rd_cmd),
		.rd_data_valid (rd_data_valid),
		.rd_data       (rd_data),
		.cu_data_valid (cu_data_valid),
		.cu_data_word  (cu_data_word)
	);

	result_merge u_result (
		.clock             (clock),
		.rstn              (rstn),
		.cu_res_valid      (cu_res_valid),
		.cu_res            (cu_res),
		.cu_edge_count     (cu_edge_count),
		.cu_res_ready      (cu_res_ready),
		.res_valid         (res_valid),
		.res_ready         (res_ready),
		.res_out           (res_out),
		.vertex_done_count (vertex_done_count),
		.edge_done_count   (edge_done_count)
	);

endmodule

`default_nettype wire

// ==== hdl/job_dispatch.sv ====
// Decode stage: buffers vertex jobs and hands them out round-robin
// Only enabled, idle units with an empty interface slot get a job
`timescale 1ns/1ps
`default_nettype none

`include "graph_cu_consts.svh"

module job_dispatch import graph_cu_pkg::*; (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled,
	input  logic [`GCU_NUM_CU-1:0] cu_enable,
	input  logic                  job_valid,
	input  vertex_job_t           job_in,
	output logic                  job_ready,
	cu_job_if.source              cu_jobs [`GCU_NUM_CU]
);

	vertex_job_t              head;
	vertex_job_t              slot_job [`GCU_NUM_CU];
	logic                     buf_empty;
	logic                     buf_afull;
	logic                     pop;
	logic [`GCU_NUM_CU-1:0]   slot_valid;
	logic [`GCU_NUM_CU-1:0]   slot_ready;
	logic [`GCU_NUM_CU-1:0]   slot_free;
	cu_id_t                   rr_ptr;
	cu_id_t                   grant_idx;

	assign job_ready = enabled && !buf_afull;

	sync_fifo #(
		.WIDTH    ($bits(vertex_job_t)),
		.DEPTH    (`GCU_JOB_DEPTH),
		.HEADROOM (1)
	) u_job_buf (
		.clock       (clock),
		.rstn        (rstn),
		.push        (job_valid && job_ready),
		.data_in     (job_in),
		.full        (),
		.almost_full (buf_afull),
		.pop         (pop),
		.data_out    (head),
		.empty       (buf_empty)
	);

	// Waiting for the unit to go idle keeps the slot fields stable for the whole job
	for (genvar i = 0; i < `GCU_NUM_CU; i++) begin : g_slot
		assign slot_ready[i]         = cu_jobs[i].ready;
		assign slot_free[i]          = cu_enable[i] && !slot_valid[i] && slot_ready[i];
		assign cu_jobs[i].valid      = slot_valid[i];
		assign cu_jobs[i].vertex_id  = slot_job[i].vertex_id;
		assign cu_jobs[i].edge_start = slot_job[i].edge_start;
		assign cu_jobs[i].edge_count = slot_job[i].edge_count;
	end

	assign grant_idx = rr_pick(slot_free, rr_ptr);
	assign pop       = enabled && !buf_empty && (|slot_free);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			slot_valid <= '0;
			rr_ptr     <= '0;
		end else begin
			for (int i = 0; i < `GCU_NUM_CU; i++) begin
				if (pop && grant_idx == cu_id_t'(i))
					slot_valid[i] <= 1'b1;
				else if (slot_ready[i])
					slot_valid[i] <= 1'b0;
			end
			if (pop)
				rr_ptr <= grant_idx + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (pop)
			slot_job[grant_idx] <= head;
	end

endmodule

`default_nettype wire

// ==== hdl/mem_port.sv ====
// Memory port: per-unit read command buffers, round-robin arbiter into a
// burst buffer, registered command output and read data routing by unit id
`timescale 1ns/1ps
`default_nettype none

`include "graph_cu_consts.svh"

module mem_port import graph_cu_pkg::*; (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic [`GCU_NUM_CU-1:0] req_valid,
	input  logic [`GCU_ADDR_W-1:0] req_addr [`GCU_NUM_CU],
	output logic [`GCU_NUM_CU-1:0] req_ready,
	output logic                   rd_cmd_valid,
	input  logic                   rd_cmd_ready,
	output read_cmd_t              rd_cmd,
	input  logic                   rd_data_valid,
	input  read_data_t             rd_data,
	output logic [`GCU_NUM_CU-1:0] cu_data_valid,
	output logic [`GCU_DATA_W-1:0] cu_data_word
);

	logic [`GCU_ADDR_W-1:0] q_addr [`GCU_NUM_CU];
	logic [`GCU_NUM_CU-1:0] q_full;
	logic [`GCU_NUM_CU-1:0] q_empty;
	logic [`GCU_NUM_CU-1:0] q_pop;
	logic [`GCU_NUM_CU-1:0] arb_req;
	logic                   grant_any;
	cu_id_t                 grant_idx;
	cu_id_t                 rr_ptr;
	logic                   arb_valid;
	read_cmd_t              arb_cmd;
	read_cmd_t              burst_head;
	logic                   burst_afull;
	logic                   burst_empty;
	logic                   burst_pop;

	////////////////////////////////////////////////////////////
	// Per-unit command buffers
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `GCU_NUM_CU; i++) begin : g_cmd_q
		assign req_ready[i] = !q_full[i];
		assign arb_req[i]   = !q_empty[i] && !burst_afull;
		assign q_pop[i]     = grant_any && (grant_idx == cu_id_t'(i));

		sync_fifo #(
			.WIDTH    (`GCU_ADDR_W),
			.DEPTH    (`GCU_CMD_DEPTH),
			.HEADROOM (1)
		) u_cmd_q (
			.clock       (clock),
			.rstn        (rstn),
			.push        (req_valid[i] && req_ready[i]),
			.data_in     (req_addr[i]),
			.full        (q_full[i]),
			.almost_full (),
			.pop         (q_pop[i]),
			.data_out    (q_addr[i]),
			.empty       (q_empty[i])
		);
	end

	assign grant_any = |arb_req;
	assign grant_idx = rr_pick(arb_req, rr_ptr);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			arb_valid <= 1'b0;
			rr_ptr    <= '0;
		end else begin
			arb_valid <= grant_any;
			if (grant_any)
				rr_ptr <= grant_idx + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (grant_any)
			arb_cmd <= '{cu_id: grant_idx, addr: q_addr[grant_idx]};
	end

	////////////////////////////////////////////////////////////
	// Burst buffer and command output register
	////////////////////////////////////////////////////////////

	// Headroom covers the grant still in flight
	sync_fifo #(
		.WIDTH    ($bits(read_cmd_t)),
		.DEPTH    (`GCU_CMD_DEPTH),
		.HEADROOM (4)
	) u_burst_q (
		.clock       (clock),
		.rstn        (rstn),
		.push        (arb_valid),
		.data_in     (arb_cmd),
		.full        (),
		.almost_full (burst_afull),
		.pop         (burst_pop),
		.data_out    (burst_head),
		.empty       (burst_empty)
	);

	assign burst_pop = !burst_empty && (!rd_cmd_valid || rd_cmd_ready);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			rd_cmd_valid <= 1'b0;
		else if (!rd_cmd_valid || rd_cmd_ready)
			rd_cmd_valid <= !burst_empty;
	end

	always_ff @(posedge clock) begin
		if (burst_pop)
			rd_cmd <= burst_head;
	end

	// Read data goes only to the unit named in its tag
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_data_valid <= '0;
		end else begin
			for (int i = 0; i < `GCU_NUM_CU; i++)
				cu_data_valid[i] <= rd_data_valid && (rd_data.cu_id == cu_id_t'(i));
		end
	end

	always_ff @(posedge clock) begin
		cu_data_word <= rd_data.word;
	end

endmodule

`default_nettype wire

// ==== hdl/result_merge.sv ====
// Result stage: merges unit results round-robin into one registered output
// and keeps the vertex and edge done totals
`timescale 1ns/1ps
`default_nettype none

`include "graph_cu_consts.svh"

module result_merge import graph_cu_pkg::*; (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic [`GCU_NUM_CU-1:0] cu_res_valid,
	input  vertex_result_t         cu_res [`GCU_NUM_CU],
	input  logic [`GCU_CNT_W-1:0]  cu_edge_count [`GCU_NUM_CU],
	output logic [`GCU_NUM_CU-1:0] cu_res_ready,
	output logic                   res_valid,
	input  logic                   res_ready,
	output vertex_result_t         res_out,
	output logic [`GCU_CNT_W-1:0]  vertex_done_count,
	output logic [`GCU_CNT_W-1:0]  edge_done_count
);

	cu_id_t                rr_ptr;
	cu_id_t                grant_idx;
	logic                  load;
	logic                  grant_any;
	logic [`GCU_CNT_W-1:0] out_edges;

	// Output register takes a new result when empty or being drained
	assign load      = !res_valid || res_ready;
	assign grant_idx = rr_pick(cu_res_valid, rr_ptr);
	assign grant_any = load && (|cu_res_valid);

	for (genvar i = 0; i < `GCU_NUM_CU; i++) begin : g_ready
		assign cu_res_ready[i] = grant_any && (grant_idx == cu_id_t'(i));
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			res_valid         <= 1'b0;
			rr_ptr            <= '0;
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else begin
			if (res_valid && res_ready) begin
				vertex_done_count <= vertex_done_count + 1'b1;
				edge_done_count   <= edge_done_count + out_edges;
			end
			if (load)
				res_valid <= |cu_res_valid;
			if (grant_any)
				rr_ptr <= grant_idx + 1'b1;
		end
	end

	// Edge count rides along with the result until it is accepted
	always_ff @(posedge clock) begin
		if (grant_any) begin
			res_out   <= cu_res[grant_idx];
			out_edges <= cu_edge_count[grant_idx];
		end
	end

	a_res_hold: assert property (@(posedge clock) disable iff (!rstn)
		res_valid && !res_ready |=> res_valid && $stable(res_out))
		else $error("result dropped or changed before res_ready");

endmodule

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
// Synchronous FIFO with show-ahead output and occupancy count
// DEPTH must be a power of two; almost_full rises HEADROOM entries before full
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH    = 8,
	parameter int DEPTH    = 16,
	parameter int HEADROOM = 1
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	output logic             almost_full,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty
);

	localparam int PTR_W = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;

	assign empty       = (count == '0);
	assign full        = (count == (PTR_W+1)'(DEPTH));
	assign almost_full = (count >= (PTR_W+1)'(DEPTH - HEADROOM));
	assign data_out    = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= data_in;
	end

	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn) !(push && full))
		else $error("push into full FIFO");
	a_no_underflow: assert property (@(posedge clock) disable iff (!rstn) !(pop && empty))
		else $error("pop from empty FIFO");

endmodule

`default_nettype wire

// ==== hdl/vertex_cu.sv ====
// Execute stage: one compute unit that reads every edge word of a vertex
// and sums them, then presents the vertex id with the sum
`timescale 1ns/1ps
`default_nettype none

`include "graph_cu_consts.svh"

module vertex_cu import graph_cu_pkg::*; (
	input  logic                   clock,
	input  logic                   rstn,
	input  cu_id_t                 cu_id,
	cu_job_if.sink                 job,
	output logic                   rd_req_valid,
	input  logic                   rd_req_ready,
	output logic [`GCU_ADDR_W-1:0] rd_req_addr,
	input  logic                   rd_data_valid,
	input  logic [`GCU_DATA_W-1:0] rd_data_word,
	output logic                   res_valid,
	input  logic                   res_ready,
	output vertex_result_t         res_out
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_FINISH
	} state_t;

	state_t                 state;
	logic [`GCU_VID_W-1:0]  vid;
	logic [`GCU_ADDR_W-1:0] base;
	logic [`GCU_CNT_W-1:0]  edge_cnt;
	logic [`GCU_CNT_W-1:0]  issue_cnt;
	logic [`GCU_CNT_W-1:0]  ret_cnt;
	logic [`GCU_CNT_W-1:0]  ret_next;
	logic [`GCU_SUM_W-1:0]  acc;

	assign job.ready    = (state == S_IDLE);
	assign rd_req_valid = (state == S_ISSUE) && (issue_cnt != edge_cnt);
	assign rd_req_addr  = base + `GCU_ADDR_W'(issue_cnt);
	assign ret_next     = ret_cnt + `GCU_CNT_W'(rd_data_valid);
	assign res_valid    = (state == S_FINISH);
	assign res_out      = '{vertex_id: vid, sum: acc};

	////////////////////////////////////////////////////////////
	// Control FSM and counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= S_IDLE;
			issue_cnt <= '0;
			ret_cnt   <= '0;
			acc       <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (job.valid) begin
						state     <= S_ISSUE;
						issue_cnt <= '0;
						ret_cnt   <= '0;
						acc       <= '0;
					end
				end
				S_ISSUE: begin
					if (rd_req_valid && rd_req_ready)
						issue_cnt <= issue_cnt + 1'b1;
					if (rd_data_valid)
						acc <= acc + `GCU_SUM_W'(rd_data_word);
					ret_cnt <= ret_next;
					// Returns never outrun issues, so this also covers zero-edge jobs
					if (ret_next == edge_cnt)
						state <= S_FINISH;
				end
				S_FINISH: begin
					if (res_ready)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Job fields, captured on acceptance
	always_ff @(posedge clock) begin
		if (state == S_IDLE && job.valid) begin
			vid      <= job.vertex_id;
			base     <= job.edge_start;
			edge_cnt <= job.edge_count;
		end
	end

	a_no_data_idle: assert property (@(posedge clock) disable iff (!rstn)
		rd_data_valid |-> state != S_IDLE)
		else $error("unit %0d got read data while idle", cu_id);

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/graph_cu_pkg.sv
hdl/graph_cu_if.sv
hdl/sync_fifo.sv
hdl/job_dispatch.sv
hdl/vertex_cu.sv
hdl/mem_port.sv
hdl/result_merge.sv
hdl/graph_cu_top.sv
verif/tb_graph_cu.sv

// ==== verif/tb_graph_cu.sv ====
// Self-checking testbench for the graph control unit
// Random jobs, a memory model with out-of-order replies and a result model
`timescale 1ns/1ps
`default_nettype none

`include "graph_cu_consts.svh"

module tb_graph_cu;

	localparam int NUM_JOBS        = 130;
	localparam int WATCHDOG_CYCLES = NUM_JOBS * 200 + 2000;

	logic                   clock;
	logic                   rstn;
	logic                   enabled_in;
	logic [2:0]             active_cu_count;
	logic                   job_valid;
	logic                   job_ready;
	logic [`GCU_VID_W-1:0]  job_vertex;
	logic [`GCU_ADDR_W-1:0] job_edge_start;
	logic [`GCU_CNT_W-1:0]  job_edge_count;
	logic                   rd_cmd_valid;
	logic                   rd_cmd_ready;
	logic [`GCU_ADDR_W-1:0] rd_cmd_addr;
	logic [1:0]             rd_cmd_cu;
	logic                   rd_data_valid;
	logic [1:0]             rd_data_cu;
	logic [`GCU_DATA_W-1:0] rd_data_word;
	logic                   res_valid;
	logic                   res_ready;
	logic [`GCU_VID_W-1:0]  res_vertex;
	logic [`GCU_SUM_W-1:0]  res_sum;
	logic [`GCU_CNT_W-1:0]  vertex_done_count;
	logic [`GCU_CNT_W-1:0]  edge_done_count;

	integer seed;
	int     error_count;
	int     check_count;
	int     tests_run;
	int     tests_failed;
	int     cycle_count;
	int     rd_stall_pct;
	int     res_stall_pct;
	int     active_lim;
	int     resp_idx;
	int     addr_left;
	int     total_jobs;
	int     total_edges;
	logic   traffic_on;
	logic   hold_wait;
	logic [`GCU_VID_W-1:0] hold_vertex;
	logic [`GCU_SUM_W-1:0] hold_sum;

	// Job list, drawn once at time zero
	logic [`GCU_VID_W-1:0]  job_vid [NUM_JOBS];
	logic [`GCU_ADDR_W-1:0] job_start [NUM_JOBS];
	logic [`GCU_CNT_W-1:0]  job_count [NUM_JOBS];

	// Reference model state
	logic [`GCU_SUM_W-1:0]  exp_sum [logic [`GCU_VID_W-1:0]];
	int                     addr_cnt [logic [`GCU_ADDR_W-1:0]];
	logic [`GCU_ADDR_W-1:0] pend_addr [$];
	logic [1:0]             pend_cu [$];
	int                     pend_due [$];

	graph_cu_top dut_i (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.active_cu_count   (active_cu_count),
		.job_valid         (job_valid),
		.job_ready         (job_ready),
		.job_vertex        (job_vertex),
		.job_edge_start    (job_edge_start),
		.job_edge_count    (job_edge_count),
		.rd_cmd_valid      (rd_cmd_valid),
		.rd_cmd_ready      (rd_cmd_ready),
		.rd_cmd_addr       (rd_cmd_addr),
		.rd_cmd_cu         (rd_cmd_cu),
		.rd_data_valid     (rd_data_valid),
		.rd_data_cu        (rd_data_cu),
		.rd_data_word      (rd_data_word),
		.res_valid         (res_valid),
		.res_ready         (res_ready),
		.res_vertex        (res_vertex),
		.res_sum           (res_sum),
		.vertex_done_count (vertex_done_count),
		.edge_done_count   (edge_done_count)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// Memory contents and reference sums
	////////////////////////////////////////////////////////////

	function automatic logic [`GCU_DATA_W-1:0] mem_word(input logic [`GCU_ADDR_W-1:0] addr);
		logic [31:0] prod;
		prod = addr * 32'd7 + 32'd3;
		return prod[`GCU_DATA_W-1:0];
	endfunction

	function automatic logic [`GCU_SUM_W-1:0] model_sum(input logic [`GCU_ADDR_W-1:0] start,
		input logic [`GCU_CNT_W-1:0] count);
		logic [`GCU_SUM_W-1:0] sum;
		sum = '0;
		for (int k = 0; k < int'(count); k++)
			sum = sum + `GCU_SUM_W'(mem_word(start + `GCU_ADDR_W'(k)));
		return sum;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("FAILED time=%0t %s: got %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (error_count != errs_before) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, error_count - errs_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// Expected sum and read addresses of one job
	task automatic expect_job(input int i);
		logic [`GCU_ADDR_W-1:0] a;
		exp_sum[job_vid[i]] = model_sum(job_start[i], job_count[i]);
		for (int k = 0; k < int'(job_count[i]); k++) begin
			a = job_start[i] + `GCU_ADDR_W'(k);
			addr_cnt[a] = addr_cnt.exists(a) ? addr_cnt[a] + 1 : 1;
		end
		addr_left   += int'(job_count[i]);
		total_jobs  += 1;
		total_edges += int'(job_count[i]);
	endtask

	// Called just after a rising edge; returns just after the accepting edge
	task automatic push_job(input int i);
		job_vertex     = job_vid[i];
		job_edge_start = job_start[i];
		job_edge_count = job_count[i];
		job_valid      = 1'b1;
		@(negedge clock);
		while (!job_ready)
			@(negedge clock);
		@(posedge clock);
		#1;
		job_valid = 1'b0;
	endtask

	task automatic run_batch(input string name, input int first, input int n,
		input int active, input int rd_stall, input int res_stall);
		int errs_before;
		errs_before = error_count;
		@(posedge clock);
		rd_stall_pct  = rd_stall;
		res_stall_pct = res_stall;
		#1;
		active_cu_count = 3'(active);
		active_lim      = active;
		// Give the active-count latch time to settle
		repeat (3) @(posedge clock);
		#1;
		for (int i = first; i < first + n; i++) begin
			expect_job(i);
			push_job(i);
		end
		while (exp_sum.num() != 0 || pend_addr.size() != 0)
			@(posedge clock);
		repeat (2) @(posedge clock);
		if (addr_left != 0) begin
			error_count++;
			$display("ERROR: %0d expected read commands were never issued", addr_left);
		end
		report_test(name, errs_before);
	endtask

	////////////////////////////////////////////////////////////
	// Per-cycle drivers: ready signals and memory replies
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		cycle_count++;
		#1;
		if (traffic_on) begin
			rd_cmd_ready = ({$random(seed)} % 100) >= rd_stall_pct;
			res_ready    = ({$random(seed)} % 100) >= res_stall_pct;
			resp_idx     = -1;
			for (int j = 0; j < pend_addr.size(); j++) begin
				if (resp_idx < 0 && pend_due[j] <= cycle_count)
					resp_idx = j;
			end
			if (resp_idx >= 0) begin
				rd_data_valid = 1'b1;
				rd_data_cu    = pend_cu[resp_idx];
				rd_data_word  = mem_word(pend_addr[resp_idx]);
				pend_addr.delete(resp_idx);
				pend_cu.delete(resp_idx);
				pend_due.delete(resp_idx);
			end else begin
				rd_data_valid = 1'b0;
			end
		end
	end

	// Monitors sample mid-cycle, where every handshake signal is stable
	always @(negedge clock) begin
		if (traffic_on) begin
			if (rd_cmd_valid && rd_cmd_ready) begin
				if (addr_cnt.exists(rd_cmd_addr) && addr_cnt[rd_cmd_addr] > 0) begin
					addr_cnt[rd_cmd_addr] = addr_cnt[rd_cmd_addr] - 1;
					addr_left--;
				end else begin
					error_count++;
					$display("ERROR: unexpected or repeated read of address %0h at %0t",
						rd_cmd_addr, $time);
				end
				if (int'(rd_cmd_cu) >= active_lim) begin
					error_count++;
					$display("ERROR: read command from disabled unit %0d at %0t",
						rd_cmd_cu, $time);
				end
				pend_addr.push_back(rd_cmd_addr);
				pend_cu.push_back(rd_cmd_cu);
				pend_due.push_back(cycle_count + 1 + int'({$random(seed)} % 8));
			end
			if (hold_wait) begin
				check_value("res_valid", res_valid, 1'b1);
				check_value("res_vertex", res_vertex, hold_vertex);
				check_value("res_sum", res_sum, hold_sum);
			end
			if (res_valid && res_ready) begin
				if (!exp_sum.exists(res_vertex)) begin
					error_count++;
					$display("ERROR: result for vertex %0h which is not pending at %0t",
						res_vertex, $time);
				end else begin
					check_value("res_sum", res_sum, exp_sum[res_vertex]);
					exp_sum.delete(res_vertex);
				end
			end
			hold_wait   = res_valid && !res_ready;
			hold_vertex = res_vertex;
			hold_sum    = res_sum;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("ERROR: watchdog expired after %0d cycles, the DUT stopped making progress",
			WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int errs_before;
		seed            = 12;
		error_count     = 0;
		check_count     = 0;
		tests_run       = 0;
		tests_failed    = 0;
		cycle_count     = 0;
		rd_stall_pct    = 0;
		res_stall_pct   = 0;
		active_lim      = 4;
		addr_left       = 0;
		total_jobs      = 0;
		total_edges     = 0;
		traffic_on      = 1'b0;
		hold_wait       = 1'b0;
		hold_vertex     = '0;
		hold_sum        = '0;
		rstn            = 1'b0;
		enabled_in      = 1'b0;
		active_cu_count = 3'd4;
		job_valid       = 1'b0;
		job_vertex      = '0;
		job_edge_start  = '0;
		job_edge_count  = '0;
		rd_cmd_ready    = 1'b0;
		rd_data_valid   = 1'b0;
		rd_data_cu      = '0;
		rd_data_word    = '0;
		res_ready       = 1'b0;

		// Unique vertex ids, random start, 0 to 12 edges
		for (int i = 0; i < NUM_JOBS; i++) begin
			job_vid[i]   = `GCU_VID_W'(16'h0100 + i);
			job_start[i] = $random(seed);
			job_count[i] = `GCU_CNT_W'({$random(seed)} % 13);
		end

		repeat (10) @(posedge clock);
		#1;
		rstn = 1'b1;

		errs_before = error_count;
		@(negedge clock);
		check_value("job_ready", job_ready, 1'b0);
		check_value("rd_cmd_valid", rd_cmd_valid, 1'b0);
		check_value("res_valid", res_valid, 1'b0);
		check_value("vertex_done_count", vertex_done_count, '0);
		check_value("edge_done_count", edge_done_count, '0);
		report_test("reset state", errs_before);
		traffic_on = 1'b1;

		@(posedge clock);
		#1;
		enabled_in = 1'b1;

		run_batch("edge sums", 0, 40, 4, 0, 0);
		run_batch("active-unit count", 40, 30, 2, 0, 0);
		run_batch("read back-pressure", 70, 30, 4, 50, 0);
		run_batch("result back-pressure", 100, 30, 4, 0, 40);

		errs_before = error_count;
		@(negedge clock);
		check_value("vertex_done_count", vertex_done_count, `GCU_CNT_W'(total_jobs));
		check_value("edge_done_count", edge_done_count, `GCU_CNT_W'(total_edges));
		report_test("totals", errs_before);

		$display("tests: %0d run, %0d failed; checks: %0d; errors: %0d",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
